/* hdl/ig_params.svh */
`ifndef IG_PARAMS_SVH
`define IG_PARAMS_SVH

// ---------------------------------------------------------------------------
// image geometry
// ---------------------------------------------------------------------------

// width in pixels, 2 or more
`define IG_IMG_W 16

// height in pixels, 2 or more
`define IG_IMG_H 16

// pixels per frame
`define IG_PIX_N (`IG_IMG_W * `IG_IMG_H)

// shared by image and gradient memories, pixel count must fit
`define IG_ADDR_W 16

`endif

/* hdl/ig_pixel_pkg.sv */
`include "ig_params.svh"

// types on the image side of the engine
package ig_pixel_pkg;

    // ------------------------------------------------------------------------
    // pixel data
    // ------------------------------------------------------------------------

    // greyscale, unsigned
    typedef logic [7:0] pixel_t;

    // ------------------------------------------------------------------------
    // addressing
    // ------------------------------------------------------------------------

    // raster index, same for image and gradient memories
    typedef logic [`IG_ADDR_W-1:0] pix_addr_t;

endpackage

/* hdl/ig_grad_pkg.sv */
`include "ig_params.svh"

// types on the gradient side of the engine
package ig_grad_pkg;

    // ------------------------------------------------------------------------
    // gradient components
    // ------------------------------------------------------------------------

    // one memory word holds both components
    localparam int GRAD_W = 20;

    // signed difference, covers -255..255
    typedef logic signed [9:0] grad_comp_t;

    // raw memory word
    typedef logic [GRAD_W-1:0] grad_raw_t;

    // gx in the upper half, gy in the lower half
    typedef struct packed {
        grad_comp_t gx;
        grad_comp_t gy;
    } grad_fields_t;

    // ------------------------------------------------------------------------
    // gradient word
    // ------------------------------------------------------------------------

    // engine fills fields, writeback ships raw
    typedef union packed {
        grad_raw_t    raw;
        grad_fields_t fields;
    } grad_word_u;

endpackage

/* hdl/ig_pixel_fetch.sv */
`timescale 1ns/1ps
`include "ig_params.svh"

module ig_pixel_fetch (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  ig_pixel_pkg::pixel_t    img_di,
    output logic                    img_rd,
    output ig_pixel_pkg::pix_addr_t img_addr,
    output logic                    pix_valid,
    output ig_pixel_pkg::pixel_t    pix_data,
    output logic                    pix_last
);
    import ig_pixel_pkg::*;

    // address of the final pixel in raster order
    localparam pix_addr_t LAST_ADDR = pix_addr_t'(`IG_PIX_N - 1);

    // frame in progress, reads plus the last return
    logic busy;
    // read counter sits on the final pixel
    logic at_last;
    // strobe and last flag delayed to line up with img_di
    logic rd_q;
    logic last_q;

    assign at_last = (img_addr == LAST_ADDR);

    // ------------------------------------------------------------------------
    // read sequencer
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            img_rd   <= 1'b0;
            img_addr <= '0;
        end else if (!busy) begin
            // start only taken while idle
            if (start) begin
                busy     <= 1'b1;
                img_rd   <= 1'b1;
                img_addr <= '0;
            end
        end else begin
            // one read per cycle, hold address on the last one
            if (img_rd) begin
                if (at_last) begin
                    img_rd <= 1'b0;
                end else begin
                    img_addr <= img_addr + pix_addr_t'(1);
                end
            end
            // back to idle once the last pixel has come back
            if (last_q) begin
                busy <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // return tagging
    // ------------------------------------------------------------------------

    // memory answers one clock after the strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_q   <= 1'b0;
            last_q <= 1'b0;
        end else begin
            rd_q   <= img_rd;
            last_q <= img_rd && at_last;
        end
    end

    assign pix_valid = rd_q;
    assign pix_last  = last_q;
    // returned pixel is only meaningful with pix_valid
    assign pix_data  = img_di;

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    // strobe only inside an accepted frame
    a_rd_only_busy: assert property (@(posedge clk) disable iff (reset)
        img_rd |-> busy);

    // never read past the frame
    a_addr_in_range: assert property (@(posedge clk) disable iff (reset)
        img_rd |-> (img_addr <= LAST_ADDR));

endmodule

/* hdl/ig_grad_engine.sv */
`timescale 1ns/1ps
`include "ig_params.svh"

module ig_grad_engine (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pix_valid,
    input  ig_pixel_pkg::pixel_t   pix_data,
    input  logic                   pix_last,
    output logic                   grad_valid,
    output ig_grad_pkg::grad_word_u grad_word,
    output logic                   grad_last
);
    import ig_pixel_pkg::*;
    import ig_grad_pkg::*;

    localparam int COL_W  = $clog2(`IG_IMG_W);
    localparam int ROW_W  = $clog2(`IG_IMG_H);
    localparam int FILL_W = $clog2(`IG_IMG_W + 1);

    // line buffer, [0] newest, [W] is the pixel being output
    pixel_t line_buf [0:`IG_IMG_W];

    // pixels taken in so far, saturates at one full row
    logic [FILL_W-1:0] fill;
    // flushing the bottom row after pix_last
    logic              flushing;
    logic [COL_W-1:0]  flush_cnt;
    logic              flush_end;
    // position of the word currently on the output
    logic [COL_W-1:0]  col;
    logic [ROW_W-1:0]  row;
    logic              last_col;
    logic              last_row;
    // shift whenever a pixel comes in or a flush word goes out
    logic              advance;

    grad_comp_t gx;
    grad_comp_t gy;

    assign advance   = pix_valid || flushing;
    assign flush_end = flushing && (flush_cnt == COL_W'(`IG_IMG_W - 1));
    assign last_col  = (col == COL_W'(`IG_IMG_W - 1));
    assign last_row  = (row == ROW_W'(`IG_IMG_H - 1));

    // ------------------------------------------------------------------------
    // line buffer
    // ------------------------------------------------------------------------

    // flush shifts in whatever is on pix_data, never reaches the output
    always_ff @(posedge clk) begin
        if (advance) begin
            line_buf[0] <= pix_data;
            for (int i = 1; i <= `IG_IMG_W; i++) begin
                line_buf[i] <= line_buf[i-1];
            end
        end
    end

    // ------------------------------------------------------------------------
    // sequencing
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            fill       <= '0;
            flushing   <= 1'b0;
            flush_cnt  <= '0;
            grad_valid <= 1'b0;
            grad_last  <= 1'b0;
            col        <= '0;
            row        <= '0;
        end else begin
            // first word once the pixel below it is in
            grad_valid <= (pix_valid && (fill == FILL_W'(`IG_IMG_W))) || flushing;
            grad_last  <= flush_end;

            if (pix_valid && (fill != FILL_W'(`IG_IMG_W))) begin
                fill <= fill + FILL_W'(1);
            end

            // bottom row comes out after the last pixel
            if (pix_valid && pix_last) begin
                flushing  <= 1'b1;
                flush_cnt <= '0;
            end else if (flush_end) begin
                flushing <= 1'b0;
            end else if (flushing) begin
                flush_cnt <= flush_cnt + COL_W'(1);
            end

            // step the output position per word issued
            if (grad_valid) begin
                if (last_col) begin
                    col <= '0;
                    row <= row + ROW_W'(1);
                end else begin
                    col <= col + COL_W'(1);
                end
            end

            // frame done, rearm for the next one
            if (grad_valid && grad_last) begin
                fill <= '0;
                col  <= '0;
                row  <= '0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // differences
    // ------------------------------------------------------------------------

    // zero-extend to 10 bits before subtracting
    always_comb begin
        gx = grad_comp_t'({2'b00, line_buf[`IG_IMG_W-1]})
           - grad_comp_t'({2'b00, line_buf[`IG_IMG_W]});
        gy = grad_comp_t'({2'b00, line_buf[0]})
           - grad_comp_t'({2'b00, line_buf[`IG_IMG_W]});
        // no right neighbour
        if (last_col) begin
            gx = '0;
        end
        // no row below
        if (last_row) begin
            gy = '0;
        end
        grad_word.fields.gx = gx;
        grad_word.fields.gy = gy;
    end

    // fetch must be finished before the flush runs
    a_no_pix_in_flush: assert property (@(posedge clk) disable iff (reset)
        flushing |-> !pix_valid);

endmodule

/* hdl/ig_grad_writeback.sv */
`timescale 1ns/1ps
`include "ig_params.svh"

module ig_grad_writeback (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    grad_valid,
    input  ig_grad_pkg::grad_word_u grad_word,
    input  logic                    grad_last,
    output logic                    grad_wr,
    output ig_pixel_pkg::pix_addr_t grad_addr,
    output ig_grad_pkg::grad_raw_t  grad_do,
    output logic                    done
);
    import ig_pixel_pkg::*;

    // address of the next word to be written
    pix_addr_t addr_cnt;
    // between accepted start and the final write
    logic      running;
    // final write is on the port this cycle
    logic      last_q;

    // ------------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr  <= 1'b0;
            last_q   <= 1'b0;
            running  <= 1'b0;
            done     <= 1'b0;
            addr_cnt <= '0;
        end else begin
            grad_wr <= grad_valid;
            last_q  <= grad_valid && grad_last;
            // start while running is dropped, same as the fetch side
            if (start && !running) begin
                running  <= 1'b1;
                done     <= 1'b0;
                addr_cnt <= '0;
            end else begin
                if (grad_valid) begin
                    addr_cnt <= addr_cnt + pix_addr_t'(1);
                end
                // done the cycle after the last write
                if (last_q) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // write port payload, raw view of the word
    always_ff @(posedge clk) begin
        if (grad_valid) begin
            grad_addr <= addr_cnt;
            grad_do   <= grad_word.raw;
        end
    end

    // done only once writes have stopped
    a_wr_not_done: assert property (@(posedge clk) disable iff (reset)
        !(grad_wr && done));

endmodule

/* hdl/ig_top.sv */
`timescale 1ns/1ps
`include "ig_params.svh"

module ig_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  ig_pixel_pkg::pixel_t    img_di,
    output logic                    img_rd,
    output ig_pixel_pkg::pix_addr_t img_addr,
    output logic                    grad_wr,
    output ig_pixel_pkg::pix_addr_t grad_addr,
    output ig_grad_pkg::grad_raw_t  grad_do,
    output logic                    done
);
    import ig_pixel_pkg::*;
    import ig_grad_pkg::*;

    // fetch to engine pixel stream
    logic       pix_valid;
    pixel_t     pix_data;
    logic       pix_last;

    // engine to writeback word stream
    logic       grad_valid;
    grad_word_u grad_word;
    logic       grad_last;

    // ------------------------------------------------------------------------
    // pipeline
    // ------------------------------------------------------------------------

    ig_pixel_fetch ig_pixel_fetch_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .img_di    (img_di),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_last  (pix_last)
    );

    ig_grad_engine ig_grad_engine_inst (
        .clk        (clk),
        .reset      (reset),
        .pix_valid  (pix_valid),
        .pix_data   (pix_data),
        .pix_last   (pix_last),
        .grad_valid (grad_valid),
        .grad_word  (grad_word),
        .grad_last  (grad_last)
    );

    ig_grad_writeback ig_grad_writeback_inst (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .grad_valid (grad_valid),
        .grad_word  (grad_word),
        .grad_last  (grad_last),
        .grad_wr    (grad_wr),
        .grad_addr  (grad_addr),
        .grad_do    (grad_do),
        .done       (done)
    );

endmodule

/* bench/ig_tb.sv */
`timescale 1ns/1ps
`include "ig_params.svh"

module ig_tb;
    import ig_pixel_pkg::*;
    import ig_grad_pkg::*;

    localparam int CLK_HALF    = 4;
    // one frame with margin, start to done is about pixels plus one row
    localparam int FRAME_LIMIT = `IG_PIX_N + `IG_IMG_W + 20;
    localparam int WATCHDOG_NS = 5 * 2 * FRAME_LIMIT * 8;

    logic      clk;
    logic      reset;
    logic      start;
    pixel_t    img_di;
    logic      img_rd;
    pix_addr_t img_addr;
    logic      grad_wr;
    pix_addr_t grad_addr;
    grad_raw_t grad_do;
    logic      done;

    // image and gradient memory models
    pixel_t    img_mem   [0:`IG_PIX_N-1];
    grad_raw_t grad_mem  [0:`IG_PIX_N-1];
    int        wr_count  [0:`IG_PIX_N-1];

    // read strobe seen in the previous cycle
    logic      rd_seen;
    pix_addr_t rd_addr_seen;

    // next address the fetch should read
    int rd_next;
    // next address the writeback should use
    int next_addr;
    int err_total;
    int pass_count;
    int fail_count;
    int seed_dummy;

    ig_top ig_top_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .img_di    (img_di),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    // ------------------------------------------------------------------------
    // clock and memories
    // ------------------------------------------------------------------------

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    // strobe captured mid-cycle, reads must walk the frame in order
    always @(negedge clk) begin
        rd_seen      = img_rd;
        rd_addr_seen = img_addr;
        if (img_rd) begin
            if (int'(img_addr) != rd_next) begin
                $display("ERR %0t: image read out of order, expected %0d got %0d",
                         $time, rd_next, img_addr);
                err_total = err_total + 1;
            end
            rd_next = int'(img_addr) + 1;
        end
    end

    // data returned one clock after the strobe, just after the edge
    always @(posedge clk) begin
        #1;
        if (rd_seen) begin
            img_di = img_mem[rd_addr_seen];
        end
    end

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------

    // right neighbour minus pixel, pixel below minus pixel, edges forced to 0
    function automatic grad_raw_t ig_ref_grad(input int idx);
        int col;
        int row;
        int dx;
        int dy;
        logic [9:0] gx_bits;
        logic [9:0] gy_bits;
        col = idx % `IG_IMG_W;
        row = idx / `IG_IMG_W;
        dx  = 0;
        dy  = 0;
        if (col != `IG_IMG_W - 1) begin
            dx = int'(img_mem[idx + 1]) - int'(img_mem[idx]);
        end
        if (row != `IG_IMG_H - 1) begin
            dy = int'(img_mem[idx + `IG_IMG_W]) - int'(img_mem[idx]);
        end
        gx_bits = dx[9:0];
        gy_bits = dy[9:0];
        return {gx_bits, gy_bits};
    endfunction

    // ------------------------------------------------------------------------
    // write checker
    // ------------------------------------------------------------------------

    // outputs are registered, so mid-cycle is stable
    always @(negedge clk) begin
        if (grad_wr) begin
            if (done) begin
                $display("write to address %0d while done was high at %0t", grad_addr, $time);
                err_total = err_total + 1;
            end
            if (int'(grad_addr) >= `IG_PIX_N) begin
                $display("write to address %0d outside the image at %0t", grad_addr, $time);
                err_total = err_total + 1;
            end else begin
                // ascending raster order
                if (int'(grad_addr) != next_addr) begin
                    $display("ERR %0t: address out of order, expected %0d got %0d",
                             $time, next_addr, grad_addr);
                    err_total = err_total + 1;
                end
                if (grad_do !== ig_ref_grad(int'(grad_addr))) begin
                    $display("ERR %0t: address %0d expected %05h got %05h",
                             $time, grad_addr, ig_ref_grad(int'(grad_addr)), grad_do);
                    err_total = err_total + 1;
                end
                grad_mem[grad_addr] = grad_do;
                wr_count[grad_addr] = wr_count[grad_addr] + 1;
                next_addr = int'(grad_addr) + 1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------

    task automatic fill_random_image();
        for (int i = 0; i < `IG_PIX_N; i++) begin
            img_mem[i] = pixel_t'($urandom);
        end
    endtask

    task automatic fill_flat_image();
        pixel_t level;
        level = pixel_t'($urandom);
        for (int i = 0; i < `IG_PIX_N; i++) begin
            img_mem[i] = level;
        end
    endtask

    // 0/255 alternating on row plus column, full-range differences
    task automatic fill_checkerboard();
        for (int i = 0; i < `IG_PIX_N; i++) begin
            img_mem[i] = (((i % `IG_IMG_W) + (i / `IG_IMG_W)) % 2 == 1) ? 8'd255 : 8'd0;
        end
    endtask

    task automatic clear_grad_mem();
        for (int i = 0; i < `IG_PIX_N; i++) begin
            grad_mem[i] = '0;
            wr_count[i] = 0;
        end
    endtask

    // one-cycle start, driven just after the edge
    task automatic pulse_start();
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
    endtask

    // every address exactly once, stored word as the reference says
    task automatic check_writes(input string name);
        for (int i = 0; i < `IG_PIX_N; i++) begin
            if (wr_count[i] == 0) begin
                $display("%s: address %0d was never written", name, i);
                err_total = err_total + 1;
            end else if (wr_count[i] > 1) begin
                $display("%s: address %0d was written %0d times", name, i, wr_count[i]);
                err_total = err_total + 1;
            end else if (grad_mem[i] !== ig_ref_grad(i)) begin
                $display("ERR %0t: stored word at address %0d expected %05h got %05h",
                         $time, i, ig_ref_grad(i), grad_mem[i]);
                err_total = err_total + 1;
            end
        end
    endtask

    // one frame from start to done, optional extra start mid-frame
    task automatic run_frame(input string name, input bit busy_start);
        int errs_before;
        int cycles;
        errs_before = err_total;
        clear_grad_mem();
        next_addr = 0;
        rd_next   = 0;
        pulse_start();
        // done falls on the start
        @(negedge clk);
        if (done) begin
            $display("%s: done stayed high after start", name);
            err_total = err_total + 1;
        end
        cycles = 1;
        if (busy_start) begin
            // well inside the frame, should be dropped
            repeat (2 * `IG_IMG_W) @(posedge clk);
            pulse_start();
            cycles = cycles + 2 * `IG_IMG_W + 2;
        end
        while (!done && cycles < FRAME_LIMIT) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (!done) begin
            $display("%s: done did not rise within %0d cycles", name, FRAME_LIMIT);
            err_total = err_total + 1;
        end else begin
            check_writes(name);
            if (rd_next != `IG_PIX_N) begin
                $display("%s: image reads ended at address %0d instead of %0d",
                         name, rd_next, `IG_PIX_N);
                err_total = err_total + 1;
            end
        end
        if (err_total == errs_before) begin
            pass_count = pass_count + 1;
            $display("test %s: passed after %0d cycles", name, cycles);
        end else begin
            fail_count = fail_count + 1;
            $display("test %s: failed with %0d errors", name, err_total - errs_before);
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        seed_dummy   = $urandom(32'h0b818ff5);
        reset        = 1'b1;
        start        = 1'b0;
        img_di       = '0;
        rd_seen      = 1'b0;
        rd_addr_seen = '0;
        rd_next      = 0;
        next_addr    = 0;
        err_total    = 0;
        pass_count   = 0;
        fail_count   = 0;
        clear_grad_mem();
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;

        fill_random_image();
        run_frame("random image", 1'b0);
        fill_flat_image();
        run_frame("flat image", 1'b0);
        fill_checkerboard();
        run_frame("checkerboard", 1'b0);
        // no reset in between, extra start while busy
        fill_random_image();
        run_frame("repeat run", 1'b1);

        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // hard stop in case the DUT hangs
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t before all tests finished", $time);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* sim.f */
+incdir+hdl
hdl/ig_pixel_pkg.sv
hdl/ig_grad_pkg.sv
hdl/ig_pixel_fetch.sv
hdl/ig_grad_engine.sv
hdl/ig_grad_writeback.sv
hdl/ig_top.sv
bench/ig_tb.sv

/* Bender.yml */
package:
  name: ig_gradient

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ig_pixel_pkg.sv
      - hdl/ig_grad_pkg.sv
      - hdl/ig_pixel_fetch.sv
      - hdl/ig_grad_engine.sv
      - hdl/ig_grad_writeback.sv
      - hdl/ig_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/ig_tb.sv
